/* cart_mapper.f */
hdl/cart_cfg_pkg.sv
hdl/cart_bus_pkg.sv
hdl/cart_map_if.sv
hdl/map_config.sv
hdl/bank_regs.sv
hdl/addr_translate.sv
hdl/cart_mapper.sv
verif/cart_checker.sv
verif/tb_cart_mapper.sv

/* hdl/addr_translate.sv */
// cart address translation
// rom and cart ram addressing from the slice map, plus the read data mux

`timescale 1ns/1ps

module addr_translate
	import cart_cfg_pkg::*, cart_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       pclk0,
	input  cpu_addr_t  address_in,
	input  byte_t      din,
	input  logic       rw,
	input  logic       cart_cs,
	input  logic [2:0] ram_bank,
	input  byte_t      rom_din,
	input  byte_t      open_bus,
	input  byte_t      cartram_data,
	cart_map_if.xlate  map,
	output rom_addr_t  rom_address,
	output cram_addr_t cartram_addr,
	output logic       cartram_wr,
	output logic       cartram_rd,
	output byte_t      cartram_wrdata,
	output byte_t      dout,
	output logic       cart_read
);

	logic [2:0]  slice;
	hw_kind_t    kind;
	byte_t       bank;
	logic [15:0] rom_off;
	logic        ram_cs;

	assign slice   = address_in[15:13];
	assign kind    = map.hw_map[slice];
	assign bank    = map.bank_map[slice];
	assign rom_off = address_in - map.address_offset;

	always_comb begin
		rom_address = '0;
		if (cart_cs) begin
			case (kind)
				hw_rom: rom_address = rom_addr_t'(rom_off);
				hw_banked_rom: begin
					case (map.bank_type)
						// 16 KB windows
						bt_supergame,
						bt_absolute:   rom_address = rom_addr_t'({bank, address_in[13:0]});
						// 8 KB windows
						bt_activision: rom_address = rom_addr_t'({bank, address_in[12:0]});
						bt_unbanked:   rom_address = rom_addr_t'(rom_off);
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// cart ram, mirror carts clear mask bits to fold the window
	assign ram_cs         = cart_cs && kind == hw_ram;
	assign cartram_addr   = cram_addr_t'({ram_bank, address_in[13:0]} & map.ram_mask);
	assign cartram_wr     = ram_cs && !rw && pclk0;
	assign cartram_rd     = !cartram_wr;
	assign cartram_wrdata = din;

	always_comb begin
		case (kind)
			hw_rom,
			hw_banked_rom: dout = rom_din;
			hw_ram:        dout = cartram_data;
			default:       dout = open_bus;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		cart_read <= rw && cart_cs;
	end

	// ram writes need a loaded mask and a known address
	a_ram_write_slice : assert property (@(posedge clk_sys)
		cartram_wr |-> !$isunknown({map.ram_mask, cartram_addr}))
		else $error("cart ram write with unknown address at %h", address_in);

endmodule : addr_translate

/* hdl/bank_regs.sv */
// cpu written cart registers
// bank, ram bank, xctrl1 and covox dac bytes, plus the covox channel sums

`timescale 1ns/1ps

module bank_regs
	import cart_cfg_pkg::*, cart_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        pclk0,
	input  cpu_addr_t   address_in,
	input  byte_t       din,
	input  logic        rw,
	input  logic        cart_cs,
	input  byte_t       cart_xm,
	input  logic [15:0] cart_flags,
	cart_map_if.regs    map,
	output byte_t       bank_reg,
	output logic [2:0]  ram_bank,
	output byte_t       xctrl1,
	output logic [15:0] covox_l,
	output logic [15:0] covox_r
);

	byte_t      covox_reg [4];
	logic       wr_strobe;
	logic       covox_cs;
	logic       xctrl1_cs;
	logic [8:0] sum_l;
	logic [8:0] sum_r;

	assign wr_strobe = pclk0 && cart_cs && !rw;
	assign covox_cs  = address_in[15:4] == page_covox;
	// xctrl1 only exists with the xm attached
	assign xctrl1_cs = cart_xm[0] && address_in[15:4] == page_xctrl && address_in[3:0] == 4'h0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank_reg  <= 8'd0;
			ram_bank  <= 3'd0;
			xctrl1    <= 8'd0;
			covox_reg <= '{default: 8'd0};
		end else if (wr_strobe) begin
			if (covox_cs)
				covox_reg[address_in[1:0]] <= din;
			if (xctrl1_cs)
				xctrl1 <= din;
			case (map.bank_type)
				bt_supergame: if (address_in[15:14] == 2'b10) begin
					// banked ram carts split the byte between rom and ram bank
					if (cart_flags[flag_sg_banked_ram]) begin
						ram_bank <= din[7:5];
						bank_reg <= {3'd0, din[4:0]};
					end else begin
						bank_reg <= din;
					end
				end
				bt_activision: if (address_in[15:4] == page_activision)
					bank_reg <= {4'd0, address_in[3:0]};
				bt_absolute: if (address_in[15])
					bank_reg <= {6'd0, din[1:0]};
				default: ;
			endcase
		end
	end

	// right takes bytes 0 and 2, left takes 1 and 3
	assign sum_r   = {1'b0, covox_reg[0]} + {1'b0, covox_reg[2]};
	assign sum_l   = {1'b0, covox_reg[1]} + {1'b0, covox_reg[3]};
	assign covox_r = {sum_r, 7'd0};
	assign covox_l = {sum_l, 7'd0};

endmodule : bank_regs

/* hdl/cart_bus_pkg.sv */
// cart bus definitions
// widths, register pages and address types seen by the mapper

package cart_bus_pkg;

	localparam int addr_w      = 16;
	localparam int data_w      = 8;
	localparam int rom_addr_w  = 25;
	localparam int cram_addr_w = 18;

	// register pages, compared against address bits 15:4
	localparam logic [11:0] page_covox      = 12'h043;
	localparam logic [11:0] page_xctrl      = 12'h047;
	localparam logic [11:0] page_activision = 12'hff8;

	typedef logic [addr_w-1:0]      cpu_addr_t;
	typedef logic [data_w-1:0]      byte_t;
	typedef logic [rom_addr_w-1:0]  rom_addr_t;
	typedef logic [cram_addr_w-1:0] cram_addr_t;

endpackage : cart_bus_pkg

/* hdl/cart_cfg_pkg.sv */
// cart configuration definitions
// flag word bit positions, slice hardware kinds, bank types and cart sizes

package cart_cfg_pkg;

	// bit positions in the 16-bit cart flag word
	localparam int flag_sg_bank       = 1;
	localparam int flag_sg_ram_4k     = 2;
	localparam int flag_rom_4k        = 3;
	localparam int flag_bank6_4k      = 4;
	localparam int flag_sg_banked_ram = 5;
	localparam int flag_mirror_ram    = 7;
	localparam int flag_activision    = 8;
	localparam int flag_absolute      = 9;

	// what sits in one 8 KB slice of the cpu map
	typedef enum logic [2:0] {
		hw_none       = 3'd0,
		hw_rom        = 3'd1,
		hw_ram        = 3'd3,
		hw_banked_rom = 3'd4
	} hw_kind_t;

	// how banked slices form the rom address
	typedef enum logic [2:0] {
		bt_supergame  = 3'd0,
		bt_activision = 3'd1,
		bt_unbanked   = 3'd2,
		bt_absolute   = 3'd3
	} bank_type_t;

	// one entry per slice, indexed by address bits 15:13
	typedef hw_kind_t hw_map_t [8];
	typedef logic [7:0] bank_map_t [8];

	// cart size thresholds in bytes
	localparam logic [31:0] size_8k  = 32'h0000_2000;
	localparam logic [31:0] size_16k = 32'h0000_4000;
	localparam logic [31:0] size_32k = 32'h0000_8000;
	localparam logic [31:0] size_48k = 32'h0000_c000;

	// 64 KB and up is always supergame
	localparam logic [31:0] size_64k = 32'h0001_0000;

endpackage : cart_cfg_pkg

/* hdl/cart_map_if.sv */
// decoded cart memory map
// carries slice kinds, banks and address adjust from config to its users

`timescale 1ns/1ps

interface cart_map_if
	import cart_cfg_pkg::*;
();

	hw_map_t     hw_map;
	bank_map_t   bank_map;
	bank_type_t  bank_type;
	logic [15:0] address_offset;
	logic [16:0] ram_mask;

	modport cfg (
		output hw_map, bank_map, bank_type, address_offset, ram_mask
	);

	// register block only needs to know how bank writes decode
	modport regs (
		input bank_type
	);

	modport xlate (
		input hw_map, bank_map, bank_type, address_offset, ram_mask
	);

endinterface : cart_map_if

/* hdl/cart_mapper.sv */
// cart mapper top level
// bank switching, register file and address translation for 7800 carts

`timescale 1ns/1ps

module cart_mapper
	import cart_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        pclk0,
	input  logic        pclk1,
	input  cpu_addr_t   address_in,
	input  byte_t       din,
	input  logic        rw,
	input  logic        cart_cs,
	input  logic [15:0] cart_flags,
	input  logic [31:0] cart_size,
	input  byte_t       rom_din,
	input  byte_t       open_bus,
	input  byte_t       cartram_data,
	input  byte_t       cart_xm,
	output byte_t       dout,
	output logic        cart_read,
	output rom_addr_t   rom_address,
	output cram_addr_t  cartram_addr,
	output logic        cartram_wr,
	output logic        cartram_rd,
	output byte_t       cartram_wrdata,
	output logic [15:0] covox_l,
	output logic [15:0] covox_r
);

	byte_t      bank_reg;
	byte_t      xctrl1;
	logic [2:0] ram_bank;

	cart_map_if map_if ();

	map_config u_map_config (
		.clk_sys    (clk_sys),
		.pclk1      (pclk1),
		.cart_flags (cart_flags),
		.cart_size  (cart_size),
		.bank_reg   (bank_reg),
		.xctrl1     (xctrl1),
		.map        (map_if.cfg)
	);

	bank_regs u_bank_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pclk0      (pclk0),
		.address_in (address_in),
		.din        (din),
		.rw         (rw),
		.cart_cs    (cart_cs),
		.cart_xm    (cart_xm),
		.cart_flags (cart_flags),
		.map        (map_if.regs),
		.bank_reg   (bank_reg),
		.ram_bank   (ram_bank),
		.xctrl1     (xctrl1),
		.covox_l    (covox_l),
		.covox_r    (covox_r)
	);

	addr_translate u_addr_translate (
		.clk_sys        (clk_sys),
		.pclk0          (pclk0),
		.address_in     (address_in),
		.din            (din),
		.rw             (rw),
		.cart_cs        (cart_cs),
		.ram_bank       (ram_bank),
		.rom_din        (rom_din),
		.open_bus       (open_bus),
		.cartram_data   (cartram_data),
		.map            (map_if.xlate),
		.rom_address    (rom_address),
		.cartram_addr   (cartram_addr),
		.cartram_wr     (cartram_wr),
		.cartram_rd     (cartram_rd),
		.cartram_wrdata (cartram_wrdata),
		.dout           (dout),
		.cart_read      (cart_read)
	);

endmodule : cart_mapper

/* hdl/map_config.sv */
// cart map configuration
// turns flags, size, bank register and xctrl1 into the registered slice map

`timescale 1ns/1ps

module map_config
	import cart_cfg_pkg::*, cart_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        pclk1,
	input  logic [15:0] cart_flags,
	input  logic [31:0] cart_size,
	input  byte_t       bank_reg,
	input  byte_t       xctrl1,
	cart_map_if.cfg     map
);

	logic        is_9b;
	logic [7:0]  bank_mask;
	logic [7:0]  highest_bank;
	logic [7:0]  second_highest_bank;
	logic [7:0]  sg_bank;
	logic [31:0] size_gap;

	hw_map_t     nxt_hw;
	bank_map_t   nxt_bank;
	bank_type_t  nxt_type;
	logic [15:0] nxt_offset;
	logic [16:0] nxt_mask;

	// highest set size bit picks the bank mask, 64 KB and below keep 2 bits
	always_comb begin
		bank_mask = 8'h03;
		for (int b = 17; b <= 22; b++) begin
			if (cart_size[b])
				bank_mask = 8'hff >> (22 - b);
		end
	end

	// rom at $4000 pushes every supergame bank up by one
	assign is_9b               = cart_flags[flag_rom_4k];
	assign highest_bank        = bank_mask + {7'd0, is_9b};
	assign second_highest_bank = is_9b ? 8'd0 : (bank_mask & 8'hfe);
	assign sg_bank             = (bank_reg & bank_mask) + {7'd0, is_9b};
	assign size_gap            = size_64k - cart_size;

	always_comb begin
		nxt_hw     = '{default: hw_none};
		nxt_bank   = '{default: 8'd0};
		nxt_type   = bt_supergame;
		nxt_offset = 16'd0;
		nxt_mask   = '1;

		if (cart_flags[flag_activision]) begin
			for (int s = 2; s < 8; s++)
				nxt_hw[s] = hw_banked_rom;
			nxt_bank[2] = 8'd13;
			nxt_bank[3] = 8'd12;
			nxt_bank[4] = 8'd15;
			nxt_bank[5] = {4'd0, bank_reg[2:0], 1'b0};
			nxt_bank[6] = {4'd0, bank_reg[2:0], 1'b1};
			nxt_bank[7] = 8'd14;
			nxt_type    = bt_activision;
		end else if (cart_flags[flag_absolute]) begin
			for (int s = 2; s < 8; s++)
				nxt_hw[s] = hw_banked_rom;
			// register value 1 or 2 selects bank 0 or 1
			nxt_bank[2] = {7'd0, bank_reg[1]};
			nxt_bank[3] = {7'd0, bank_reg[1]};
			nxt_bank[4] = 8'd2;
			nxt_bank[5] = 8'd2;
			nxt_bank[6] = 8'd3;
			nxt_bank[7] = 8'd3;
			nxt_type    = bt_absolute;
		end else if (cart_flags[flag_sg_bank] || cart_size >= size_64k) begin
			for (int s = 2; s < 8; s++)
				nxt_hw[s] = hw_banked_rom;
			nxt_bank[2] = second_highest_bank;
			nxt_bank[3] = second_highest_bank;
			nxt_bank[4] = sg_bank;
			nxt_bank[5] = sg_bank;
			nxt_bank[6] = highest_bank;
			nxt_bank[7] = highest_bank;
			nxt_type    = bt_supergame;
		end else begin
			// plain rom fills down from the top of the map
			if (cart_size <= size_8k)
				nxt_hw[7] = hw_rom;
			else if (cart_size <= size_16k)
				nxt_hw[6:7] = '{hw_rom, hw_rom};
			else if (cart_size <= size_32k)
				nxt_hw[4:7] = '{hw_rom, hw_rom, hw_rom, hw_rom};
			else if (cart_size <= size_48k)
				nxt_hw[2:7] = '{hw_rom, hw_rom, hw_rom, hw_rom, hw_rom, hw_rom};
			nxt_offset = size_gap[15:0];
			nxt_type   = bt_unbanked;
		end

		// $4000 overrides, first matching flag wins
		if (cart_flags[flag_sg_ram_4k] || cart_flags[flag_sg_banked_ram]) begin
			nxt_hw[2] = hw_ram;
			nxt_hw[3] = hw_ram;
		end else if (cart_flags[flag_mirror_ram]) begin
			nxt_hw[2]         = hw_ram;
			nxt_hw[3]         = hw_ram;
			nxt_mask[8]       = 1'b0;
			nxt_mask[13:12]   = 2'b00;
		end else if (cart_flags[flag_bank6_4k]) begin
			nxt_hw[2]   = hw_banked_rom;
			nxt_hw[3]   = hw_banked_rom;
			nxt_bank[2] = 8'd6;
			nxt_bank[3] = 8'd6;
		end

		// xm ram windows at $4000 and $6000
		if (xctrl1[5])
			nxt_hw[2] = hw_ram;
		if (xctrl1[6])
			nxt_hw[3] = hw_ram;
	end

	always_ff @(posedge clk_sys) begin
		if (pclk1) begin
			map.hw_map         <= nxt_hw;
			map.bank_map       <= nxt_bank;
			map.bank_type      <= nxt_type;
			map.address_offset <= nxt_offset;
			map.ram_mask       <= nxt_mask;
		end
	end

	// once loaded, every slice holds a known kind
	for (genvar i = 0; i < 8; i++) begin : g_slice_chk
		a_slice_kind : assert property (@(posedge clk_sys)
			pclk1 |=> !$isunknown(map.hw_map[i]))
			else $error("slice %0d holds an undefined hardware kind", i);
	end

endmodule : map_config

/* run_sim.sh */
#!/bin/sh
# builds the cart mapper testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_mapper -f cart_mapper.f

out=$(./obj_dir/Vtb_cart_mapper) || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "TEST OK"

/* verif/cart_checker.sv */
// cart mapper checker
// compares the dut ports against the expected bus values and counts errors

`timescale 1ns/1ps

module cart_checker
	import cart_bus_pkg::*;
(
	input  logic         clk_sys,
	input  logic         check_en,
	input  logic [127:0] test_name,
	input  rom_addr_t    exp_rom,
	input  cram_addr_t   exp_cram,
	input  logic         exp_wr,
	input  byte_t        exp_dout,
	input  byte_t        exp_wrdata,
	input  logic         exp_read,
	input  logic [15:0]  exp_covox_l,
	input  logic [15:0]  exp_covox_r,
	input  rom_addr_t    rom_address,
	input  cram_addr_t   cartram_addr,
	input  logic         cartram_wr,
	input  logic         cartram_rd,
	input  byte_t        cartram_wrdata,
	input  byte_t        dout,
	input  logic         cart_read,
	input  logic [15:0]  covox_l,
	input  logic [15:0]  covox_r,
	output int           errors,
	output int           checks
);

	int   err_count = 0;
	int   chk_count = 0;
	logic read_pending = 1'b0;
	logic read_exp = 1'b0;

	assign errors = err_count;
	assign checks = chk_count;

	task automatic compare_field(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			err_count++;
			$display("[ERROR] %0s %0s expected %h actual %h", test_name, field,
				expected, actual);
		end
	endtask

	// outputs are combinational from inputs driven just after the rising edge
	always @(negedge clk_sys) begin
		// cart_read lags the bus cycle by one clock
		if (read_pending) begin
			compare_field("cart_read", 32'(read_exp), 32'(cart_read));
			read_pending = 1'b0;
		end
		if (check_en) begin
			chk_count++;
			compare_field("rom_address", 32'(exp_rom), 32'(rom_address));
			compare_field("cartram_addr", 32'(exp_cram), 32'(cartram_addr));
			compare_field("cartram_wr", 32'(exp_wr), 32'(cartram_wr));
			compare_field("cartram_rd", 32'(!exp_wr), 32'(cartram_rd));
			compare_field("cartram_wrdata", 32'(exp_wrdata), 32'(cartram_wrdata));
			compare_field("dout", 32'(exp_dout), 32'(dout));
			compare_field("covox_l", 32'(exp_covox_l), 32'(covox_l));
			compare_field("covox_r", 32'(exp_covox_r), 32'(covox_r));
			read_exp = exp_read;
			read_pending = 1'b1;
		end
	end

endmodule : cart_checker

/* verif/tb_cart_mapper.sv */
// cart mapper testbench
// drives cart types, register writes and bus reads, with a reference model

`timescale 1ns/1ps

module tb_cart_mapper
	import cart_cfg_pkg::*, cart_bus_pkg::*;
();

	logic        clk_sys, reset, pclk0, pclk1, rw, cart_cs;
	cpu_addr_t   address_in;
	byte_t       din, rom_din, open_bus, cartram_data, cart_xm;
	logic [15:0] cart_flags;
	logic [31:0] cart_size;
	byte_t       dout, cartram_wrdata;
	logic        cart_read, cartram_wr, cartram_rd;
	rom_addr_t   rom_address;
	cram_addr_t  cartram_addr;
	logic [15:0] covox_l, covox_r;

	// register model
	byte_t       m_bank;
	logic [2:0]  m_ram_bank;
	byte_t       m_xctrl1;
	byte_t       m_covox [4];

	rom_addr_t    exp_rom;
	cram_addr_t   exp_cram;
	logic         exp_wr;
	byte_t        exp_dout;
	byte_t        exp_wrdata;
	logic         exp_read;
	logic [15:0]  exp_cl, exp_cr;
	logic         check_en;
	logic [127:0] test_name;
	int           errors, checks, timeouts;
	int           seed;
	logic [31:0]  rnd;

	logic [31:0] u_sizes [2] = '{size_16k, size_48k};
	logic [15:0] ram_flags [2] = '{16'h0004, 16'h0080};

	cart_mapper uut (.*);

	cart_checker u_checker (
		.clk_sys (clk_sys), .check_en (check_en), .test_name (test_name),
		.exp_rom (exp_rom), .exp_cram (exp_cram), .exp_wr (exp_wr),
		.exp_dout (exp_dout), .exp_wrdata (exp_wrdata), .exp_read (exp_read),
		.exp_covox_l (exp_cl), .exp_covox_r (exp_cr),
		.rom_address (rom_address), .cartram_addr (cartram_addr),
		.cartram_wr (cartram_wr), .cartram_rd (cartram_rd),
		.cartram_wrdata (cartram_wrdata), .dout (dout), .cart_read (cart_read),
		.covox_l (covox_l), .covox_r (covox_r), .errors (errors), .checks (checks)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		#500_000;
		$display("simulation watchdog expired before the test sequence ended");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic banked_mode();
		return cart_flags[flag_activision] || cart_flags[flag_absolute] ||
			cart_flags[flag_sg_bank] || cart_size >= size_64k;
	endfunction

	// slice contents from the cart type, $4000 options and xctrl1
	function automatic hw_kind_t ref_kind(input logic [2:0] s);
		hw_kind_t k;
		int       rom_slices;
		k = hw_none;
		rom_slices = cart_size <= size_8k ? 1 : cart_size <= size_16k ? 2 :
			cart_size <= size_32k ? 4 : cart_size <= size_48k ? 6 : 0;
		if (banked_mode()) begin
			if (s >= 3'd2)
				k = hw_banked_rom;
		end else if (rom_slices > 0 && int'(s) >= 8 - rom_slices) begin
			k = hw_rom;
		end
		if (s == 3'd2 || s == 3'd3) begin
			if (cart_flags[flag_sg_ram_4k] || cart_flags[flag_sg_banked_ram] ||
				cart_flags[flag_mirror_ram])
				k = hw_ram;
			else if (cart_flags[flag_bank6_4k])
				k = hw_banked_rom;
		end
		if ((s == 3'd2 && m_xctrl1[5]) || (s == 3'd3 && m_xctrl1[6]))
			k = hw_ram;
		return k;
	endfunction

	function automatic rom_addr_t ref_rom(input cpu_addr_t a);
		int         banks;
		logic [7:0] mask, top, bank;
		logic [2:0] s;
		s = a[15:13];
		banks = int'(cart_size >> 14);
		mask = banks > 4 ? 8'(banks - 1) : 8'd3;
		top = mask + {7'd0, cart_flags[flag_rom_4k]};
		if (cart_flags[flag_activision]) begin
			case (s)
				3'd2: bank = 8'd13;
				3'd3: bank = 8'd12;
				3'd4: bank = 8'd15;
				3'd5: bank = {4'd0, m_bank[2:0], 1'b0};
				3'd6: bank = {4'd0, m_bank[2:0], 1'b1};
				default: bank = 8'd14;
			endcase
		end else if (cart_flags[flag_absolute]) begin
			if (s < 3'd4)
				bank = (m_bank == 8'd2) ? 8'd1 : 8'd0;
			else
				bank = {6'd0, s[2:1]};
		end else if (s < 3'd4) begin
			bank = cart_flags[flag_rom_4k] ? 8'd0 : top - 8'd1;
		end else if (s < 3'd6) begin
			bank = (m_bank & mask) + {7'd0, cart_flags[flag_rom_4k]};
		end else begin
			bank = top;
		end
		if (cart_flags[flag_bank6_4k] && (s == 3'd2 || s == 3'd3))
			bank = 8'd6;
		if (!banked_mode())
			return rom_addr_t'(16'(32'(a) + cart_size - size_64k));
		if (cart_flags[flag_activision])
			return rom_addr_t'({bank, a[12:0]});
		return rom_addr_t'({bank, a[13:0]});
	endfunction

	function automatic void ref_bus(input cpu_addr_t a, input logic is_write,
		output rom_addr_t rom, output cram_addr_t cram, output logic wr, output byte_t d);
		hw_kind_t    kind;
		logic [16:0] mask;
		kind = ref_kind(a[15:13]);
		mask = 17'h1ffff;
		// mirror carts fold address bits 8, 12 and 13
		if (cart_flags[flag_mirror_ram] && !cart_flags[flag_sg_ram_4k] &&
			!cart_flags[flag_sg_banked_ram])
			mask = 17'h1ffff & ~17'h03100;
		rom = (kind == hw_rom || kind == hw_banked_rom) ? ref_rom(a) : '0;
		cram = cram_addr_t'({m_ram_bank, a[13:0]} & mask);
		wr = kind == hw_ram && is_write && pclk0;
		if (kind == hw_rom || kind == hw_banked_rom)
			d = rom_din;
		else if (kind == hw_ram)
			d = cartram_data;
		else
			d = open_bus;
	endfunction

	// one cycle, pclk0 and pclk1 take turns
	task automatic step();
		@(posedge clk_sys);
		#1;
		pclk0 = !pclk0;
		pclk1 = !pclk0;
	endtask

	task automatic wait_pclk0();
		int n;
		n = 0;
		step();
		while (!pclk0 && n < 8) begin
			step();
			n++;
		end
		if (!pclk0) begin
			timeouts++;
			$display("timeout, no pclk0 strobe within 8 cycles");
		end
	endtask

	// lets a pclk1 edge load the map
	task automatic settle();
		repeat (4) step();
	endtask

	task automatic configure(input logic [15:0] flags, input logic [31:0] size);
		cart_flags = flags;
		cart_size = size;
		settle();
	endtask

	task automatic clear_model();
		m_bank = 8'd0;
		m_ram_bank = 3'd0;
		m_xctrl1 = 8'd0;
		m_covox = '{default: 8'd0};
	endtask

	task automatic write_reg(input cpu_addr_t a, input byte_t d);
		wait_pclk0();
		address_in = a;
		din = d;
		rw = 1'b0;
		cart_cs = 1'b1;
		if (a[15:4] == page_covox)
			m_covox[a[1:0]] = d;
		if (a[15:4] == page_xctrl && a[3:0] == 4'h0 && cart_xm[0])
			m_xctrl1 = d;
		if (cart_flags[flag_activision]) begin
			if (a[15:4] == page_activision)
				m_bank = {4'd0, a[3:0]};
		end else if (cart_flags[flag_absolute]) begin
			if (a[15])
				m_bank = {6'd0, d[1:0]};
		end else if (banked_mode() && a[15:14] == 2'b10) begin
			if (cart_flags[flag_sg_banked_ram]) begin
				m_bank = {3'd0, d[4:0]};
				m_ram_bank = d[7:5];
			end else begin
				m_bank = d;
			end
		end
		step();
		rw = 1'b1;
		cart_cs = 1'b0;
		settle();
	endtask

	task automatic check_bus(input logic [127:0] name, input cpu_addr_t a,
		input logic is_write);
		logic [31:0] r;
		if (is_write)
			wait_pclk0();
		else
			step();
		r = $random(seed);
		address_in = a;
		din = r[7:0];
		rom_din = r[15:8];
		open_bus = r[23:16];
		cartram_data = r[31:24];
		rw = !is_write;
		cart_cs = 1'b1;
		test_name = name;
		ref_bus(a, is_write, exp_rom, exp_cram, exp_wr, exp_dout);
		// write data passes straight through, a read cycle flags cart_read
		exp_wrdata = r[7:0];
		exp_read = !is_write;
		exp_cl = 16'((int'(m_covox[1]) + int'(m_covox[3])) * 128);
		exp_cr = 16'((int'(m_covox[0]) + int'(m_covox[2])) * 128);
		check_en = 1'b1;
		step();
		check_en = 1'b0;
		rw = 1'b1;
		cart_cs = 1'b0;
	endtask

	initial begin
		seed = 32'ha9ac_17a0;
		timeouts = 0;
		reset = 1'b1;
		pclk0 = 1'b0;
		pclk1 = 1'b0;
		rw = 1'b1;
		cart_cs = 1'b0;
		address_in = '0;
		din = '0;
		rom_din = '0;
		open_bus = '0;
		cartram_data = '0;
		cart_xm = '0;
		cart_flags = '0;
		cart_size = size_16k;
		check_en = 1'b0;
		exp_wrdata = '0;
		exp_read = 1'b0;
		test_name = "reset";
		clear_model();
		repeat (16) step();
		reset = 1'b0;
		settle();

		// unbanked carts
		foreach (u_sizes[i]) begin
			configure(16'h0000, u_sizes[i]);
			repeat (8) begin
				rnd = $random(seed);
				check_bus("unbanked_rom", 16'h4000 + 16'(rnd % 32'hc000), 1'b0);
				check_bus("unbanked_open", {2'b00, rnd[29:16]}, 1'b0);
			end
		end

		// supergame 128 KB, then with banked ram
		configure(16'h0002, 32'h0002_0000);
		repeat (4) begin
			rnd = $random(seed);
			write_reg(16'h8000, rnd[7:0]);
			check_bus("sg_bank", {2'b10, rnd[21:8]}, 1'b0);
			check_bus("sg_top", {2'b11, rnd[31:18]}, 1'b0);
		end
		configure(16'h0022, 32'h0002_0000);
		repeat (4) begin
			rnd = $random(seed);
			write_reg(16'h8000, rnd[7:0]);
			check_bus("sg_ram_wr", {3'b011, rnd[20:8]}, 1'b1);
			check_bus("sg_ram_rd", {3'b011, rnd[30:18]}, 1'b0);
			check_bus("sg_bank_ram", {2'b10, rnd[29:16]}, 1'b0);
		end

		// activision and absolute
		configure(16'h0100, 32'h0002_0000);
		repeat (4) begin
			rnd = $random(seed);
			write_reg({12'hff8, rnd[3:0]}, 8'h00);
			repeat (4) begin
				rnd = $random(seed);
				check_bus("activision", 16'h4000 + 16'(rnd % 32'hc000), 1'b0);
			end
		end
		configure(16'h0200, size_64k);
		for (int b = 1; b <= 2; b++) begin
			write_reg(16'h8000, 8'(b));
			repeat (6) begin
				rnd = $random(seed);
				check_bus("absolute", 16'h4000 + 16'(rnd % 32'hc000), 1'b0);
			end
		end

		// ram at $4000, plain and mirrored
		foreach (ram_flags[i]) begin
			configure(ram_flags[i], size_32k);
			repeat (6) begin
				rnd = $random(seed);
				check_bus("ram4k_wr", {4'b0101, rnd[11:0]}, 1'b1);
				check_bus("ram4k_wr", {3'b011, rnd[28:16]}, 1'b1);
				check_bus("ram4k_rd", {3'b011, rnd[28:16]}, 1'b0);
			end
		end

		// xctrl1 bit 5, ignored without the xm
		configure(16'h0000, size_32k);
		cart_xm = 8'h00;
		write_reg(16'h4700, 8'h20);
		check_bus("xctrl_no_xm", 16'h5123, 1'b0);
		cart_xm = 8'h01;
		write_reg(16'h4700, 8'h20);
		rnd = $random(seed);
		check_bus("xctrl_ram_wr", {4'b0101, rnd[11:0]}, 1'b1);
		check_bus("xctrl_ram_rd", {4'b0101, rnd[27:16]}, 1'b0);
		write_reg(16'h4700, 8'h00);
		check_bus("xctrl_off", 16'h5123, 1'b0);

		// covox bytes, then a reset clears them
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			write_reg(16'h4300 + 16'(i), rnd[7:0]);
		end
		check_bus("covox", 16'hc000, 1'b0);
		reset = 1'b1;
		step();
		step();
		reset = 1'b0;
		clear_model();
		settle();
		check_bus("covox_reset", 16'hc000, 1'b0);

		step();
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : tb_cart_mapper
